// ==== Bender.yml ====
package:
  name: div_periph

sources:
  # packages first, then the core and the register block
  - hw/div_pkg.sv
  - hw/divreg_pkg.sv
  - hw/msb_index.sv
  - hw/div_core.sv
  - hw/div_regs.sv
  - hw/div_periph.sv

  - target: simulation
    files:
      - sim/tb_div_periph.sv

// ==== hw/div_core.sv ====
`timescale 1ns/1ps

module div_core (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       start,
    input  logic                       sign,
    input  logic                       abort,
    input  logic [div_pkg::DATA_W-1:0] dividend,
    input  logic [div_pkg::DATA_W-1:0] divisor,
    output logic                       busy,
    output logic                       done,
    output logic                       div_zero,
    output logic [div_pkg::DATA_W-1:0] quotient,
    output logic [div_pkg::DATA_W-1:0] remainder
);
    import div_pkg::*;

    logic [1:0]        state;
    logic [1:0]        state_nxt;
    logic [DATA_W-1:0] a_mag;
    logic [DATA_W-1:0] b_mag;
    logic [CNT_W-1:0]  a_len;
    logic [CNT_W-1:0]  b_len;
    logic [CNT_W-1:0]  a_len_q;
    logic [CNT_W-1:0]  b_len_q;
    logic [CNT_W-1:0]  step_cnt;
    logic [CNT_W-1:0]  shamt;
    logic              sign_q;
    logic              a_sgn;
    logic              b_sgn;
    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] quo_acc;
    logic [DATA_W:0]   den_q;
    logic [DATA_W:0]   den_shr;
    logic [DATA_W:0]   minus;
    logic              take;
    logic              short_cut;
    logic              last_step;

    assign a_mag = (sign && dividend[DATA_W-1]) ? -dividend : dividend;
    assign b_mag = (sign && divisor[DATA_W-1]) ? -divisor : divisor;

    msb_index u_len_a (
        .value  (a_mag),
        .length (a_len)
    );

    msb_index u_len_b (
        .value  (b_mag),
        .length (b_len)
    );

    assign take      = start && (state == ST_IDLE);  // start only counts in idle
    assign short_cut = (b_len_q == '0) || (b_len_q > a_len_q);
    assign last_step = (step_cnt == '0);
    assign shamt     = a_len_q - b_len_q + 1'b1;
    assign den_shr   = den_q >> 1;
    assign minus     = {1'b0, rem_q} - den_shr;  // msb set means borrow

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                    state_nxt = ST_INIT;
            end
            ST_INIT:
            begin
                if (short_cut)
                    state_nxt = ST_DONE;
                else
                    state_nxt = ST_CALC;
            end
            ST_CALC:
            begin
                if (last_step)
                    state_nxt = ST_DONE;
            end
            ST_DONE:
            begin
                state_nxt = ST_IDLE;
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= ST_IDLE;
        else if (abort)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // control, lengths and published results
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            sign_q    <= 1'b0;
            a_sgn     <= 1'b0;
            b_sgn     <= 1'b0;
            a_len_q   <= '0;
            b_len_q   <= '0;
            step_cnt  <= '0;
            quotient  <= '0;
            remainder <= '0;
            div_zero  <= 1'b0;
        end
        else if (abort)
        begin
            sign_q    <= 1'b0;
            a_sgn     <= 1'b0;
            b_sgn     <= 1'b0;
            a_len_q   <= '0;
            b_len_q   <= '0;
            step_cnt  <= '0;
            quotient  <= '0;
            remainder <= '0;
            div_zero  <= 1'b0;
        end
        else
        begin
            if (take)
            begin
                sign_q    <= sign;
                a_sgn     <= dividend[DATA_W-1];
                b_sgn     <= divisor[DATA_W-1];
                a_len_q   <= a_len;
                b_len_q   <= b_len;
                quotient  <= '0;
                remainder <= '0;
                div_zero  <= 1'b0;
            end
            if (state == ST_INIT)
                step_cnt <= a_len_q - b_len_q;  // calc runs this plus one cycles
            else if (state == ST_CALC)
                step_cnt <= step_cnt - 1'b1;
            if (state == ST_DONE)
            begin
                quotient  <= (sign_q && (a_sgn ^ b_sgn)) ? -quo_acc : quo_acc;
                remainder <= (sign_q && a_sgn) ? -rem_q : rem_q;  // follows dividend
                div_zero  <= (b_len_q == '0);
            end
        end
    end

    // datapath: partial remainder, aligned divisor, quotient bits
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            rem_q   <= a_mag;
            den_q   <= {1'b0, b_mag};
            quo_acc <= '0;
        end
        else if (state == ST_INIT)
        begin
            den_q <= den_q << shamt;  // one past the dividend's top bit
        end
        else if (state == ST_CALC)
        begin
            den_q   <= den_shr;
            quo_acc <= {quo_acc[DATA_W-2:0], ~minus[DATA_W]};
            if (!minus[DATA_W])
                rem_q <= minus[DATA_W-1:0];
        end
    end

endmodule

// ==== hw/div_periph.sv ====
`timescale 1ns/1ps

module div_periph (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [divreg_pkg::ADR_W-1:0]  wb_adr,
    input  logic [3:0]                    wb_sel,
    input  logic [div_pkg::DATA_W-1:0]    wb_dat_w,
    output logic [div_pkg::DATA_W-1:0]    wb_dat_r,
    output logic                          wb_ack
);
    import div_pkg::*;

    logic              start;
    logic              sign;
    logic              abort;
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
    logic              busy;
    logic              done;
    logic              div_zero;
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;

    div_regs u_regs (
        .clk       (clk),
        .rstn      (rstn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .start     (start),
        .sign      (sign),
        .abort     (abort),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .div_zero  (div_zero),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_core u_core (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .sign      (sign),
        .abort     (abort),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .div_zero  (div_zero),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

// ==== hw/div_pkg.sv ====
package div_pkg;

    // operand and result width, one bus word
    localparam int DATA_W = 32;

    // bit lengths run 0..32 and step counts 0..31
    localparam int CNT_W = 6;

    localparam logic [1:0] ST_IDLE = 2'd0;  // waiting for start
    localparam logic [1:0] ST_INIT = 2'd1;  // align divisor, check short path
    localparam logic [1:0] ST_CALC = 2'd2;  // one shift-subtract per cycle
    localparam logic [1:0] ST_DONE = 2'd3;  // fix signs, publish results

endpackage

// ==== hw/div_regs.sv ====
`timescale 1ns/1ps

module div_regs (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [divreg_pkg::ADR_W-1:0]  wb_adr,
    input  logic [3:0]                    wb_sel,
    input  logic [div_pkg::DATA_W-1:0]    wb_dat_w,
    output logic [div_pkg::DATA_W-1:0]    wb_dat_r,
    output logic                          wb_ack,
    output logic                          start,
    output logic                          sign,
    output logic                          abort,
    output logic [div_pkg::DATA_W-1:0]    dividend,
    output logic [div_pkg::DATA_W-1:0]    divisor,
    input  logic                          busy,
    input  logic                          done,
    input  logic                          div_zero,
    input  logic [div_pkg::DATA_W-1:0]    quotient,
    input  logic [div_pkg::DATA_W-1:0]    remainder
);
    import div_pkg::*;
    import divreg_pkg::*;

    logic              req;
    logic              wr_ctrl;
    logic              done_q;
    ctrl_word_u        cmd_w;
    ctrl_word_u        sts_w;
    logic [DATA_W-1:0] rd_word;

    // new request only, the held one during ack is already served
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr_ctrl = req && wb_we && (wb_adr == REG_CTRL) && wb_sel[0];
    assign cmd_w   = wb_dat_w;

    always_comb
    begin
        sts_w              = '0;
        sts_w.sts.busy     = busy;
        sts_w.sts.sign     = sign;
        sts_w.sts.done     = done_q;
        sts_w.sts.div_zero = div_zero;
    end

    always_comb
    begin
        rd_word = '0;  // unmapped reads as zero
        case (wb_adr)
            REG_DIVIDEND:  rd_word = dividend;
            REG_DIVISOR:   rd_word = divisor;
            REG_CTRL:      rd_word = sts_w;
            REG_QUOTIENT:  rd_word = quotient;
            REG_REMAINDER: rd_word = remainder;
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            wb_ack <= 1'b0;
        else
            wb_ack <= req;
    end

    always_ff @(posedge clk)
    begin
        if (req)
            wb_dat_r <= rd_word;
    end

    // operand registers, byte lanes
    always_ff @(posedge clk)
    begin
        if (req && wb_we)
        begin
            for (int b = 0; b < DATA_W / 8; b++)
            begin
                if (wb_sel[b] && (wb_adr == REG_DIVIDEND))
                    dividend[8*b +: 8] <= wb_dat_w[8*b +: 8];
                if (wb_sel[b] && (wb_adr == REG_DIVISOR))
                    divisor[8*b +: 8] <= wb_dat_w[8*b +: 8];
            end
        end
    end

    // command pulses line up with the ack
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            start <= 1'b0;
            abort <= 1'b0;
            sign  <= 1'b0;
        end
        else
        begin
            start <= wr_ctrl && cmd_w.cmd.start;
            abort <= wr_ctrl && cmd_w.cmd.abort;
            if (wr_ctrl)
                sign <= cmd_w.cmd.sign;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            done_q <= 1'b0;
        else if (abort || (start && !busy))  // core takes start only when idle
            done_q <= 1'b0;
        else if (done)
            done_q <= 1'b1;
    end

endmodule

// ==== hw/divreg_pkg.sv ====
package divreg_pkg;

    // word address bits, byte offset = word address * 4
    localparam int ADR_W = 3;

    localparam logic [ADR_W-1:0] REG_DIVIDEND  = 3'd0;  // 0x00
    localparam logic [ADR_W-1:0] REG_DIVISOR   = 3'd1;  // 0x04
    localparam logic [ADR_W-1:0] REG_CTRL      = 3'd2;  // 0x08
    localparam logic [ADR_W-1:0] REG_QUOTIENT  = 3'd3;  // 0x0c
    localparam logic [ADR_W-1:0] REG_REMAINDER = 3'd4;  // 0x10

    // control word seen as a command on write and as status on read
    typedef union packed {
        struct packed {
            logic [28:0] unused;
            logic        abort;     // bit 2
            logic        sign;      // bit 1, signed mode
            logic        start;     // bit 0
        } cmd;
        struct packed {
            logic [27:0] zero;
            logic        div_zero;  // bit 3
            logic        done;      // bit 2, sticky
            logic        sign;      // bit 1
            logic        busy;      // bit 0
        } sts;
    } ctrl_word_u;

endpackage

// ==== hw/msb_index.sv ====
`timescale 1ns/1ps

module msb_index (
    input  logic [div_pkg::DATA_W-1:0] value,
    output logic [div_pkg::CNT_W-1:0]  length
);
    import div_pkg::*;

    // highest set bit wins, zero input gives zero
    always_comb
    begin
        length = '0;
        for (int i = 0; i < DATA_W; i++)
        begin
            if (value[i])
            begin
                length = CNT_W'(i + 1);
            end
        end
    end

endmodule

// ==== sim/tb_div_periph.sv ====
`timescale 1ns/1ps

module tb_div_periph;
    import div_pkg::*;
    import divreg_pkg::*;

    localparam int          CLK_HALF    = 20;     // 40 ns period
    localparam int          RST_CYCLES  = 4;
    localparam int          TIMEOUT_CYC = 20000;  // ~130 divisions of 40 cycles plus bus traffic
    localparam int          ACK_WAIT    = 4;
    localparam int          MAX_POLLS   = 40;     // 35 cycle worst case at two cycles per poll
    localparam int          N_RANDOM    = 50;
    localparam logic [31:0] SEED        = 32'h9375630c;

    logic              clk;
    logic              rstn;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADR_W-1:0]  wb_adr;
    logic [3:0]        wb_sel;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;

    int          errors;
    int          checks;
    int          tests;
    int          cycle_cnt;
    int unsigned seed_val;

    div_periph dut (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input ctrl_word_u exp, input ctrl_word_u act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s expected %h actual %h (busy %b sign %b done %b div_zero %b)",
                     name, exp, act, act.sts.busy, act.sts.sign, act.sts.done, act.sts.div_zero);
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [3:0] sel,
                            input logic [DATA_W-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = data;
        for (int n = 0; n < ACK_WAIT; n++)
        begin
            @(negedge clk);
            if (wb_ack)
                break;
        end
        if (!wb_ack)
        begin
            errors++;
            $display("no ack within %0d cycles on write to word address %0d", ACK_WAIT, adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wb_sel = 4'hf;
        for (int n = 0; n < ACK_WAIT; n++)
        begin
            @(negedge clk);
            if (wb_ack)
                break;
        end
        data = wb_dat_r;
        if (!wb_ack)
        begin
            errors++;
            data = 'x;
            $display("no ack within %0d cycles on read of word address %0d", ACK_WAIT, adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic read_status(output ctrl_word_u s);
        logic [DATA_W-1:0] d;
        wb_read(REG_CTRL, d);
        s = d;
    endtask

    task automatic write_cmd(input logic start, input logic sgn, input logic abort);
        ctrl_word_u c;
        c           = '0;
        c.cmd.start = start;
        c.cmd.sign  = sgn;
        c.cmd.abort = abort;
        wb_write(REG_CTRL, 4'hf, c);
    endtask

    function automatic ctrl_word_u status_of(input logic busy, input logic sgn,
                                             input logic done, input logic dz);
        ctrl_word_u s;
        s              = '0;
        s.sts.busy     = busy;
        s.sts.sign     = sgn;
        s.sts.done     = done;
        s.sts.div_zero = dz;
        return s;
    endfunction

    // truncating division with the dividend's sign on the remainder
    task automatic ref_div(input logic sgn, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b, output logic [DATA_W-1:0] q,
                           output logic [DATA_W-1:0] r);
        longint sa;
        longint sb;
        if (sgn)
        begin
            sa = $signed(a);
            sb = $signed(b);
        end
        else
        begin
            sa = {32'b0, a};
            sb = {32'b0, b};
        end
        if (sb == 0)
        begin
            q = '0;
            r = a;  // zero divisor passes the dividend through
        end
        else
        begin
            q = 32'(sa / sb);
            r = 32'(sa % sb);
        end
    endtask

    task automatic wait_done(input string name, output ctrl_word_u s);
        for (int n = 0; n < MAX_POLLS; n++)
        begin
            read_status(s);
            if (s.sts.done)
                break;
        end
        if (!s.sts.done)
        begin
            errors++;
            $display("%s: division did not finish within %0d status polls", name, MAX_POLLS);
        end
    endtask

    task automatic run_div(input string name, input logic sgn, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] q_exp;
        logic [DATA_W-1:0] r_exp;
        logic [DATA_W-1:0] d;
        ctrl_word_u        s;
        string             tag;
        tag = $sformatf("%s %h/%h", name, a, b);
        ref_div(sgn, a, b, q_exp, r_exp);
        wb_write(REG_DIVIDEND, 4'hf, a);
        wb_write(REG_DIVISOR, 4'hf, b);
        write_cmd(1'b1, sgn, 1'b0);
        wait_done(tag, s);
        check_status({tag, " status"}, status_of(1'b0, sgn, 1'b1, b == '0), s);
        wb_read(REG_QUOTIENT, d);
        check_word({tag, " quotient"}, q_exp, d);
        wb_read(REG_REMAINDER, d);
        check_word({tag, " remainder"}, r_exp, d);
    endtask

    task automatic finish_test(input string name, input int e0, input int c0);
        tests++;
        $display("test %-12s checks %0d errors %0d", name, checks - c0, errors - e0);
    endtask

    task automatic test_regs();
        int                e0;
        int                c0;
        logic [DATA_W-1:0] d;
        ctrl_word_u        s;
        e0 = errors;
        c0 = checks;
        read_status(s);
        check_status("regs reset status", '0, s);
        wb_write(REG_DIVIDEND, 4'hf, 32'h12345678);
        wb_read(REG_DIVIDEND, d);
        check_word("regs dividend", 32'h12345678, d);
        wb_write(REG_DIVISOR, 4'hf, 32'h9abcdef0);
        wb_read(REG_DIVISOR, d);
        check_word("regs divisor", 32'h9abcdef0, d);
        wb_write(REG_DIVISOR, 4'b0101, 32'h11223344);  // lanes 0 and 2
        wb_read(REG_DIVISOR, d);
        check_word("regs divisor lanes", 32'h9a22de44, d);
        wb_write(REG_DIVIDEND, 4'b1000, 32'hff000000);
        wb_read(REG_DIVIDEND, d);
        check_word("regs dividend lane 3", 32'hff345678, d);
        wb_write(REG_QUOTIENT, 4'hf, 32'hdeadbeef);
        wb_read(REG_QUOTIENT, d);
        check_word("regs quotient read only", '0, d);
        wb_write(REG_REMAINDER, 4'hf, 32'hdeadbeef);
        wb_read(REG_REMAINDER, d);
        check_word("regs remainder read only", '0, d);
        for (int adr = 5; adr < 8; adr++)
        begin
            wb_write(ADR_W'(adr), 4'hf, 32'hffffffff);
            wb_read(ADR_W'(adr), d);
            check_word($sformatf("regs unmapped %0d", adr), '0, d);
        end
        finish_test("registers", e0, c0);
    endtask

    task automatic test_unsigned();
        int                e0;
        int                c0;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        e0 = errors;
        c0 = checks;
        run_div("unsigned", 1'b0, 32'd0, 32'd1);
        run_div("unsigned", 1'b0, 32'd1, 32'd1);
        run_div("unsigned", 1'b0, 32'hffffffff, 32'd1);
        run_div("unsigned", 1'b0, 32'hffffffff, 32'hffffffff);
        run_div("unsigned", 1'b0, 32'h80000000, 32'd3);
        run_div("unsigned", 1'b0, 32'd12345, 32'd12345);
        run_div("unsigned", 1'b0, 32'hfffffffe, 32'hffffffff);
        for (int i = 0; i < N_RANDOM; i++)
        begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);  // spread the divisor lengths
            if (b == '0)
                b = 32'd1;
            run_div("unsigned", 1'b0, a, b);
        end
        finish_test("unsigned", e0, c0);
    endtask

    task automatic test_signed();
        int                e0;
        int                c0;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        e0 = errors;
        c0 = checks;
        run_div("signed", 1'b1, 32'd100, 32'd7);
        run_div("signed", 1'b1, -32'd100, 32'd7);
        run_div("signed", 1'b1, 32'd100, -32'd7);
        run_div("signed", 1'b1, -32'd100, -32'd7);
        run_div("signed", 1'b1, 32'h80000000, 32'hffffffff);  // overflow wraps
        run_div("signed", 1'b1, 32'h80000000, 32'h80000000);
        for (int i = 0; i < N_RANDOM; i++)
        begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            if ($urandom % 2)
                b = -b;
            if (b == '0)
                b = 32'd3;
            run_div("signed", 1'b1, a, b);
        end
        finish_test("signed", e0, c0);
    endtask

    task automatic test_zero_short();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        run_div("div by zero", 1'b0, 32'hcafef00d, 32'd0);
        run_div("div by zero", 1'b1, -32'd77, 32'd0);
        run_div("div by zero", 1'b0, 32'd0, 32'd0);
        run_div("short", 1'b0, 32'd5, 32'd100);
        run_div("short", 1'b1, -32'd5, 32'd100);
        run_div("short", 1'b1, 32'd9, 32'h80000000);
        finish_test("zero/short", e0, c0);
    endtask

    task automatic test_status();
        int                e0;
        int                c0;
        logic [DATA_W-1:0] d;
        ctrl_word_u        s;
        e0 = errors;
        c0 = checks;
        wb_write(REG_DIVIDEND, 4'hf, 32'hffffffff);  // longest unsigned case
        wb_write(REG_DIVISOR, 4'hf, 32'd1);
        write_cmd(1'b1, 1'b0, 1'b0);
        read_status(s);
        check_status("status busy after start", status_of(1'b1, 1'b0, 1'b0, 1'b0), s);
        wb_write(REG_DIVIDEND, 4'hf, 32'd100);
        wb_write(REG_DIVISOR, 4'hf, 32'd7);
        write_cmd(1'b1, 1'b0, 1'b0);  // dropped while the core is busy
        read_status(s);
        check_status("status still busy", status_of(1'b1, 1'b0, 1'b0, 1'b0), s);
        wait_done("status first result", s);
        wb_read(REG_QUOTIENT, d);
        check_word("status kept quotient", 32'hffffffff, d);
        wb_read(REG_REMAINDER, d);
        check_word("status kept remainder", '0, d);
        read_status(s);
        check_status("status done sticky", status_of(1'b0, 1'b0, 1'b1, 1'b0), s);
        write_cmd(1'b1, 1'b0, 1'b0);
        read_status(s);
        check_status("status done cleared by start", status_of(1'b1, 1'b0, 1'b0, 1'b0), s);
        wait_done("status second result", s);
        wb_read(REG_QUOTIENT, d);
        check_word("status second quotient", 32'd14, d);
        wb_read(REG_REMAINDER, d);
        check_word("status second remainder", 32'd2, d);
        write_cmd(1'b0, 1'b0, 1'b1);  // results and done are set here
        read_status(s);
        check_status("status done cleared by abort", '0, s);
        wb_read(REG_QUOTIENT, d);
        check_word("status abort quotient", '0, d);
        wb_read(REG_REMAINDER, d);
        check_word("status abort remainder", '0, d);
        wb_write(REG_DIVIDEND, 4'hf, 32'hffffffff);
        wb_write(REG_DIVISOR, 4'hf, 32'd1);
        write_cmd(1'b1, 1'b0, 1'b0);
        read_status(s);
        check_status("status busy before abort", status_of(1'b1, 1'b0, 1'b0, 1'b0), s);
        write_cmd(1'b0, 1'b0, 1'b1);
        read_status(s);
        check_status("status busy cleared by abort", '0, s);
        finish_test("status", e0, c0);
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, tests did not complete", TIMEOUT_CYC);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        clk      = 1'b0;
        rstn     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_sel   = '0;
        wb_dat_w = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        seed_val = $urandom(SEED);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_regs();
        test_unsigned();
        test_signed();
        test_zero_short();
        test_status();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/div_pkg.sv
hw/divreg_pkg.sv
hw/msb_index.sv
hw/div_core.sv
hw/div_regs.sv
hw/div_periph.sv
sim/tb_div_periph.sv
